/* hw/reg_pkg.sv */
`default_nettype none

package reg_pkg;

    // Register bus widths
    localparam int addr_w = 14;
    localparam int data_w = 16;

    // Bank field of the word address
    localparam int bank_sel_hi = 13;
    localparam int bank_sel_lo = 9;
    localparam int bank_w      = bank_sel_hi - bank_sel_lo + 1;

    localparam logic [bank_w-1:0] bank_general = 5'd0;
    localparam logic [bank_w-1:0] bank_conv    = 5'd1;
    localparam logic [bank_w-1:0] bank_pool    = 5'd2;

    localparam int general_words = 4;
    localparam int conv_words    = 8;
    localparam int pool_words    = 4;

    // SPI frame layout, cmd and addr first
    localparam int spi_frame_bits = 32;
    localparam int spi_addr_bits  = 16;

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } reg_req_t;

    // Word 0 sits in the top field of every bank struct
    typedef struct packed {
        logic [data_w-1:0] ctrl;
        logic [data_w-1:0] layer_count;
        logic [data_w-1:0] src_base;
        logic [data_w-1:0] dst_base;
    } general_regs_t;

    typedef struct packed {
        logic [data_w-1:0] in_width;
        logic [data_w-1:0] in_height;
        logic [data_w-1:0] in_chan;
        logic [data_w-1:0] out_chan;
        logic [data_w-1:0] kernel;
        logic [data_w-1:0] stride;
        logic [data_w-1:0] padding;
        logic [data_w-1:0] weight_base;
    } conv_regs_t;

    typedef struct packed {
        logic [data_w-1:0] pool_type;
        logic [data_w-1:0] window;
        logic [data_w-1:0] stride;
        logic [data_w-1:0] out_width;
    } pool_regs_t;

endpackage

`default_nettype wire

/* hw/spi_bit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_bit_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       sclk_rise,
    output logic [5:0] bit_count,
    output logic       addr_done,
    output logic       frame_done
);
    import reg_pkg::*;

    localparam logic [5:0] addr_last  = 6'(spi_addr_bits - 1);
    localparam logic [5:0] frame_last = 6'(spi_frame_bits - 1);

    // Sampled rising edges of the open frame
    always_ff @(posedge clk)
    begin
        if (rst || clear)
        begin
            bit_count <= '0;
        end
        else if (sclk_rise)
        begin
            bit_count <= bit_count + 6'd1;
        end
    end

    // Pulses on the edge that completes each field
    assign addr_done  = sclk_rise && !clear && (bit_count == addr_last);
    assign frame_done = sclk_rise && !clear && (bit_count == frame_last);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Sequencer must clear us before a 33rd edge can land
    count_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        bit_count <= 6'(spi_frame_bits)
    ) else $error("spi bit count ran past frame length");

endmodule

`default_nettype wire

/* hw/spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  logic              clk,
    input  logic              rst,
    input  logic              sclk,
    input  logic              mosi,
    input  logic              ss,
    output logic              miso,
    input  logic [15:0]       spi_rdata,
    output reg_pkg::reg_req_t spi_req
);
    import reg_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_cmd_addr,
        st_read_wait,
        st_data,
        st_done
    } state_t;

    state_t            state;
    logic              sclk_meta;
    logic              sclk_sync;
    logic              sclk_prev;
    logic              mosi_meta;
    logic              mosi_sync;
    logic              ss_meta;
    logic              ss_sync;
    logic              sclk_rise;
    logic              sclk_fall;
    logic              cnt_clear;
    logic [5:0]        bit_count;
    logic              addr_done;
    logic              frame_done;
    logic [14:0]       rx_shift;
    logic [15:0]       rx_next;
    logic [15:0]       tx_shift;
    logic              write_flag;
    logic              req_wr;
    logic              req_rd;
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_wdata;

    ////////////////////////////////////////
    // Pin synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
            // SS idles high
            ss_meta   <= 1'b1;
            ss_sync   <= 1'b1;
        end
        else
        begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;
            ss_meta   <= ss;
            ss_sync   <= ss_meta;
        end
    end

    assign sclk_rise = sclk_sync && !sclk_prev;
    assign sclk_fall = !sclk_sync && sclk_prev;

    // Counter only runs inside an open frame
    assign cnt_clear = (state == st_idle) || (state == st_done);

    spi_bit_counter u_bit_counter (
        .clk        (clk),
        .rst        (rst),
        .clear      (cnt_clear),
        .sclk_rise  (sclk_rise),
        .bit_count  (bit_count),
        .addr_done  (addr_done),
        .frame_done (frame_done)
    );

    ////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= st_idle;
            req_wr <= 1'b0;
            req_rd <= 1'b0;
            miso   <= 1'b0;
        end
        else
        begin
            req_wr <= 1'b0;
            req_rd <= 1'b0;
            case (state)
                st_idle:
                begin
                    miso <= 1'b0;
                    if (!ss_sync)
                        state <= st_cmd_addr;
                end
                st_cmd_addr:
                begin
                    if (ss_sync)
                        state <= st_idle;
                    else if (addr_done && write_flag)
                        state <= st_data;
                    else if (addr_done)
                    begin
                        req_rd <= 1'b1;
                        state  <= st_read_wait;
                    end
                end
                st_read_wait:
                begin
                    // Stay through the strobe cycle, mux latches data then
                    if (ss_sync)
                        state <= st_idle;
                    else if (!req_rd)
                        state <= st_data;
                end
                st_data:
                begin
                    if (ss_sync)
                    begin
                        state <= st_idle;
                    end
                    else
                    begin
                        if (sclk_fall)
                            miso <= tx_shift[15];
                        if (frame_done)
                        begin
                            req_wr <= write_flag;
                            state  <= st_done;
                        end
                    end
                end
                st_done:
                begin
                    miso <= 1'b0;
                    if (ss_sync)
                        state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // Shift registers and request fields
    ////////////////////////////////////////

    assign rx_next = {rx_shift, mosi_sync};

    always_ff @(posedge clk)
    begin
        if (sclk_rise)
            rx_shift <= rx_next[14:0];
        // First bit of the frame is the write flag
        if (state == st_cmd_addr && sclk_rise && bit_count == 6'd0)
            write_flag <= mosi_sync;
        if (addr_done)
            req_addr <= rx_next[addr_w-1:0];
        if (frame_done)
            req_wdata <= rx_next;

        if (state == st_idle)
            tx_shift <= '0;
        else if (state == st_read_wait && !req_rd)
            tx_shift <= spi_rdata;
        else if (state == st_data && sclk_fall)
            tx_shift <= {tx_shift[14:0], 1'b0};
    end

    assign spi_req = '{wr: req_wr, rd: req_rd, addr: req_addr, wdata: req_wdata};

endmodule

`default_nettype wire

/* hw/reg_intf_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_intf_mux (
    input  logic              clk,
    input  logic              rst,
    input  logic              spi_or_driver,
    input  reg_pkg::reg_req_t spi_req,
    output logic [15:0]       spi_rdata,
    input  logic [13:0]       paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [15:0]       pwdata,
    output logic [15:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output reg_pkg::reg_req_t bus_req,
    input  logic [15:0]       rdata_general,
    input  logic [15:0]       rdata_conv,
    input  logic [15:0]       rdata_pool
);
    import reg_pkg::*;

    logic              apb_done;
    logic [bank_w-1:0] bank;
    logic              mapped;
    logic [data_w-1:0] rdata_sel;

    // APB access phase completes only while driver owns the bus
    assign apb_done = psel && penable && !spi_or_driver;
    assign pready   = apb_done;

    ////////////////////////////////////////
    // Source select
    ////////////////////////////////////////

    always_comb
    begin
        if (spi_or_driver)
        begin
            bus_req = spi_req;
        end
        else
        begin
            bus_req.wr    = apb_done && pwrite;
            bus_req.rd    = apb_done && !pwrite;
            bus_req.addr  = paddr;
            bus_req.wdata = pwdata;
        end
    end

    ////////////////////////////////////////
    // Bank decode and read return
    ////////////////////////////////////////

    assign bank = bus_req.addr[bank_sel_hi:bank_sel_lo];

    always_comb
    begin
        mapped = 1'b1;
        case (bank)
            bank_general: rdata_sel = rdata_general;
            bank_conv:    rdata_sel = rdata_conv;
            bank_pool:    rdata_sel = rdata_pool;
            default:
            begin
                mapped    = 1'b0;
                rdata_sel = '0;
            end
        endcase
    end

    assign prdata  = rdata_sel;
    assign pslverr = apb_done && !mapped;

    // Hold SPI read word for the transmit load
    always_ff @(posedge clk)
    begin
        if (spi_or_driver && spi_req.rd)
            spi_rdata <= rdata_sel;
    end

    // At most one strobe, and none lasts past a single cycle
    one_strobe: assert property (
        @(posedge clk) disable iff (rst)
        !(bus_req.wr && bus_req.rd) &&
        !((bus_req.wr || bus_req.rd) && $past(bus_req.wr || bus_req.rd))
    ) else $error("bus_req strobes overlap or last more than one cycle");

endmodule

`default_nettype wire

/* hw/regfile_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_bank #(
    parameter type        regs_t  = reg_pkg::general_regs_t,
    parameter logic [4:0] bank_id = reg_pkg::bank_general,
    parameter int         words   = reg_pkg::general_words
) (
    input  logic              clk,
    input  logic              rst,
    input  reg_pkg::reg_req_t bus_req,
    output logic [15:0]       rdata,
    output regs_t             regs
);
    import reg_pkg::*;

    localparam int idx_w = $clog2(words);

    logic [data_w-1:0]       mem [words];
    logic [bank_sel_lo-1:0]  offset;
    logic [idx_w-1:0]        idx;
    logic                    hit;
    logic                    in_range;
    logic [words*data_w-1:0] flat;

    // Word offset inside the bank
    assign offset   = bus_req.addr[bank_sel_lo-1:0];
    assign idx      = offset[idx_w-1:0];
    assign hit      = (bus_req.addr[bank_sel_hi:bank_sel_lo] == bank_id);
    assign in_range = (offset < words);

    ////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < words; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (bus_req.wr && hit && in_range)
        begin
            mem[idx] <= bus_req.wdata;
        end
    end

    // Out of range offsets read as zero
    assign rdata = in_range ? mem[idx] : '0;

    // Pack with word 0 on top
    always_comb
    begin
        for (int i = 0; i < words; i++)
        begin
            flat[(words-1-i)*data_w +: data_w] = mem[i];
        end
    end

    assign regs = regs_t'(flat);

    layout_fits: assert property (
        @(posedge clk)
        $bits(regs_t) == words * data_w
    ) else $error("bank %0d layout width does not match word count", bank_id);

endmodule

`default_nettype wire

/* hw/reg_intf.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_intf (
    input  logic                   clk,
    input  logic                   rst,

    // SPI pins from off-chip host
    input  logic                   sclk,
    input  logic                   mosi,
    input  logic                   ss,
    output logic                   miso,

    // Bus owner select from controller
    input  logic                   spi_or_driver,

    // APB from program driver
    input  logic [13:0]            paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [15:0]            pwdata,
    output logic [15:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,

    // Configuration to compute engines
    output reg_pkg::general_regs_t general_regs,
    output reg_pkg::conv_regs_t    conv_regs,
    output reg_pkg::pool_regs_t    pool_regs
);
    import reg_pkg::*;

    reg_req_t          spi_req;
    reg_req_t          bus_req;
    logic [data_w-1:0] spi_rdata;
    logic [data_w-1:0] rdata_general;
    logic [data_w-1:0] rdata_conv;
    logic [data_w-1:0] rdata_pool;

    spi_slave u_spi_slave (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .mosi      (mosi),
        .ss        (ss),
        .miso      (miso),
        .spi_rdata (spi_rdata),
        .spi_req   (spi_req)
    );

    reg_intf_mux u_reg_intf_mux (
        .clk           (clk),
        .rst           (rst),
        .spi_or_driver (spi_or_driver),
        .spi_req       (spi_req),
        .spi_rdata     (spi_rdata),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .bus_req       (bus_req),
        .rdata_general (rdata_general),
        .rdata_conv    (rdata_conv),
        .rdata_pool    (rdata_pool)
    );

    ////////////////////////////////////////
    // Register banks
    ////////////////////////////////////////

    regfile_bank #(
        .regs_t  (general_regs_t),
        .bank_id (bank_general),
        .words   (general_words)
    ) u_bank_general (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .rdata   (rdata_general),
        .regs    (general_regs)
    );

    regfile_bank #(
        .regs_t  (conv_regs_t),
        .bank_id (bank_conv),
        .words   (conv_words)
    ) u_bank_conv (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .rdata   (rdata_conv),
        .regs    (conv_regs)
    );

    regfile_bank #(
        .regs_t  (pool_regs_t),
        .bank_id (bank_pool),
        .words   (pool_words)
    ) u_bank_pool (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .rdata   (rdata_pool),
        .regs    (pool_regs)
    );

endmodule

`default_nettype wire

/* testbench/tb_reg_intf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_reg_intf;
    import reg_pkg::*;

    localparam int clk_half     = 4;
    localparam int sample_delay = 2;
    localparam int reset_cycles = 16;
    localparam int spi_half     = 5;
    localparam int apb_tests    = 260;
    localparam int spi_tests    = 60;
    // About 300 APB accesses of 4 cycles and 60 SPI frames of 330, with margin
    localparam int timeout_cycles = 40000;

    logic              clk;
    logic              rst;
    logic              sclk;
    logic              mosi;
    logic              ss;
    logic              miso;
    logic              spi_or_driver;
    logic [addr_w-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
    general_regs_t     general_regs;
    conv_regs_t        conv_regs;
    pool_regs_t        pool_regs;

    // Reference model, 16 words per bank
    logic [data_w-1:0] model [3][16];
    logic [31:0]       rng_state;
    int                mismatch_count;
    int                protocol_count;
    int                cycle_count = 0;

    reg_intf u_reg_intf (
        .clk           (clk),
        .rst           (rst),
        .sclk          (sclk),
        .mosi          (mosi),
        .ss            (ss),
        .miso          (miso),
        .spi_or_driver (spi_or_driver),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .general_regs  (general_regs),
        .conv_regs     (conv_regs),
        .pool_regs     (pool_regs)
    );

    always #clk_half clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Random numbers and model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        begin
            y = x ^ (x << 13);
            y = y ^ (y >> 17);
            y = y ^ (y << 5);
            return y;
        end
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic int bank_words(input int bank_num);
        case (bank_num)
            0:       return general_words;
            1:       return conv_words;
            2:       return pool_words;
            default: return 0;
        endcase
    endfunction

    function automatic logic is_mapped(input logic [addr_w-1:0] addr);
        return addr[bank_sel_hi:bank_sel_lo] < 5'd3;
    endfunction

    // Unmapped banks and offsets past the word count read zero
    function automatic logic [data_w-1:0] model_read(input logic [addr_w-1:0] addr);
        int bank_num;
        int offset;
        begin
            bank_num = int'(addr[bank_sel_hi:bank_sel_lo]);
            offset   = int'(addr[bank_sel_lo-1:0]);
            if (bank_num < 3 && offset < bank_words(bank_num))
                return model[bank_num][offset];
            return '0;
        end
    endfunction

    task automatic model_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        int bank_num;
        int offset;
        begin
            bank_num = int'(addr[bank_sel_hi:bank_sel_lo]);
            offset   = int'(addr[bank_sel_lo-1:0]);
            if (bank_num < 3 && offset < bank_words(bank_num))
                model[bank_num][offset] = data;
        end
    endtask

    task automatic random_addr(output logic [addr_w-1:0] addr);
        logic [31:0] r;
        int          bank_num;
        logic [4:0]  bank;
        begin
            next_rand(r);
            if (r[2:0] < 3'd6)
                bank_num = int'(r[15:8]) % 3;
            else
                bank_num = 3 + int'(r[15:8]) % 29;
            bank = bank_num[4:0];
            // Offset bit 8 lands past every bank's word count
            addr = {bank, r[20] & r[21], 4'b0000, r[19:16]};
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
            mismatch_count++;
        end
    endtask

    // Word 0 sits in the top field of each struct
    task automatic check_banks();
        logic [63:0]  exp_general;
        logic [127:0] exp_conv;
        logic [63:0]  exp_pool;
        begin
            exp_general = {model[0][0], model[0][1], model[0][2], model[0][3]};
            exp_conv    = {model[1][0], model[1][1], model[1][2], model[1][3],
                           model[1][4], model[1][5], model[1][6], model[1][7]};
            exp_pool    = {model[2][0], model[2][1], model[2][2], model[2][3]};
            check_value("general_regs", 128'(general_regs), 128'(exp_general));
            check_value("conv_regs", 128'(conv_regs), exp_conv);
            check_value("pool_regs", 128'(pool_regs), 128'(exp_pool));
        end
    endtask

    ////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////

    // Starts and ends just after a falling edge
    task automatic apb_access(input logic [addr_w-1:0] addr, input logic wr,
                              input logic [data_w-1:0] wdata, input int hold);
        logic [data_w-1:0] got_rdata;
        logic              got_err;
        logic              done;
        int                waited;
        begin
            paddr         = addr;
            pwrite        = wr;
            pwdata        = wdata;
            psel          = 1'b1;
            penable       = 1'b0;
            spi_or_driver = (hold > 0);
            @(negedge clk);
            penable   = 1'b1;
            done      = 1'b0;
            waited    = 0;
            got_rdata = '0;
            got_err   = 1'b0;
            while (!done)
            begin
                #sample_delay;
                if (spi_or_driver)
                begin
                    assert (!pready && !pslverr)
                    else
                    begin
                        $display("APB access responded while the SPI side owned the bus");
                        protocol_count++;
                    end
                    check_banks();
                    waited++;
                    @(negedge clk);
                    if (waited >= hold)
                        spi_or_driver = 1'b0;
                end
                else
                begin
                    assert (pready)
                    else
                    begin
                        $display("APB access did not complete in its first free cycle");
                        protocol_count++;
                    end
                    got_rdata = prdata;
                    got_err   = pslverr;
                    done      = 1'b1;
                end
            end
            check_value("pslverr", 128'(got_err), 128'(!is_mapped(addr)));
            if (!wr || !is_mapped(addr))
                check_value("prdata", 128'(got_rdata), 128'(model_read(addr)));
            if (wr)
                model_write(addr, wdata);
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
            check_banks();
        end
    endtask

    // Mode 0 frame, MOSI changes with the falling SCLK
    task automatic spi_frame(input logic wr, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] wdata);
        logic [31:0]       frame;
        logic [31:0]       r;
        logic [data_w-1:0] got;
        int                i;
        begin
            next_rand(r);
            frame         = {wr, r[0], addr, wr ? wdata : r[31:16]};
            got           = '0;
            spi_or_driver = 1'b1;
            ss            = 1'b0;
            repeat (spi_half) @(negedge clk);
            for (i = 31; i >= 0; i--)
            begin
                mosi = frame[i];
                repeat (spi_half) @(negedge clk);
                // MISO settles during the low half
                if (i < data_w)
                    got[i] = miso;
                sclk = 1'b1;
                repeat (spi_half) @(negedge clk);
                sclk = 1'b0;
            end
            repeat (spi_half) @(negedge clk);
            ss   = 1'b1;
            mosi = 1'b0;
            repeat (2 * spi_half) @(negedge clk);
            spi_or_driver = 1'b0;
            assert (miso === 1'b0)
            else
            begin
                $display("MISO stayed high after the frame ended");
                protocol_count++;
            end
            if (wr)
                model_write(addr, wdata);
            else
                check_value("miso", 128'(got), 128'(model_read(addr)));
            check_banks();
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        logic [31:0]       r;
        logic [addr_w-1:0] addr;
        int                hold;
        int                n;

        clk            = 1'b0;
        rst            = 1'b1;
        sclk           = 1'b0;
        mosi           = 1'b0;
        ss             = 1'b1;
        spi_or_driver  = 1'b0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        rng_state      = 32'hbbb5_796e;
        mismatch_count = 0;
        protocol_count = 0;
        for (int b = 0; b < 3; b++)
        begin
            for (int w = 0; w < 16; w++)
            begin
                model[b][w] = '0;
            end
        end

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        assert (!pready && !pslverr && !miso)
        else
        begin
            $display("Outputs were not idle after reset");
            protocol_count++;
        end
        check_banks();

        // Mapped, unmapped and held APB traffic
        for (n = 0; n < apb_tests; n++)
        begin
            next_rand(r);
            random_addr(addr);
            hold = (r[3:0] < 4'd3) ? 3 + int'(r[7:4]) % 8 : 0;
            apb_access(addr, r[8], r[31:16], hold);
        end

        // SPI frames, each write read back over APB
        for (n = 0; n < spi_tests; n++)
        begin
            next_rand(r);
            random_addr(addr);
            spi_frame(r[0], addr, r[31:16]);
            if (r[0])
                apb_access(addr, 1'b0, '0, 0);
        end

        $display("Mismatches: %0d, protocol failures: %0d", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/reg_pkg.sv
hw/spi_bit_counter.sv
hw/spi_slave.sv
hw/reg_intf_mux.sv
hw/regfile_bank.sv
hw/reg_intf.sv
testbench/tb_reg_intf.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the reg_intf testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_reg_intf \
    -f vlog.f \
    -o tb_reg_intf
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_reg_intf > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$log_file"; then
    exit 1
fi

exit 0
